// File: smc_defs.svh
/*
  static memory controller parameters
  bus widths and fixed access phase lengths,
  shared by the RTL and the testbench
*/

`ifndef SMC_DEFS_SVH
`define SMC_DEFS_SVH

// --------------------
// bus widths
// --------------------
`define SMC_DATA_W 32
// external word address
`define SMC_ADDR_W 10
// byte lanes
`define SMC_SEL_W 4

// --------------------
// phase lengths, clock cycles
// --------------------
`define SMC_SETUP_CYC 1
`define SMC_STROBE_CYC 2
`define SMC_HOLD_CYC 1
// phase counter width, covers the longest phase
`define SMC_CNT_W 3

`endif

// File: smc_pkg.sv
/*
  static memory controller types
  sequencer state and access direction
*/

package smc_pkg;

  // --------------------
  // sequencer states
  // --------------------
  // idle   waits for a Wishbone request
  // setup  address and chip select settle
  // strobe output enable or write strobe active
  // hold   strobes released, address held
  // ack    one cycle Wishbone acknowledge
  typedef enum logic [2:0]
  {
    st_idle   = 3'd0,
    st_setup  = 3'd1,
    st_strobe = 3'd2,
    st_hold   = 3'd3,
    st_ack    = 3'd4
  } smc_state_t;

  // access direction, taken from wb_we
  typedef enum logic
  {
    dir_read  = 1'b0,
    dir_write = 1'b1
  } smc_dir_t;

endpackage

// File: smc_strobe_if.sv
/*
  sequencer to write enable stage strobes
  raw active-low write enables and write strobe,
  plus the full-cycle qualifier, all one cycle ahead of the pins
*/

`timescale 1ns/10ps
`include "smc_defs.svh"

interface smc_strobe_if;

  // high for the cycles that precede each strobe pin cycle
  logic                  r_full;
  // raw per-byte write enables, low on selected lanes of a write
  logic [`SMC_SEL_W-1:0] n_r_we;
  // raw write strobe, low for a whole write access
  logic                  n_r_wr;

  // --------------------
  // views
  // --------------------
  // sequencer side drives everything
  modport sequencer
  (
    output r_full,
    output n_r_we,
    output n_r_wr
  );

  // enable stage only listens
  modport enable
  (
    input r_full,
    input n_r_we,
    input n_r_wr
  );

endinterface

// File: smc_strobe.sv
/*
  static memory strobe sequencer
  Wishbone classic slave, single reads and writes;
  runs each access through setup, strobe and hold phases,
  holds address and write data, captures read data at the end of strobe
  and produces raw write strobes one cycle ahead for the enable stage
*/

`timescale 1ns/10ps
`include "smc_defs.svh"

module smc_strobe
(
  input  logic                   sys_clk,
  input  logic                   reset,
  // Wishbone slave
  input  logic                   wb_cyc,
  input  logic                   wb_stb,
  input  logic                   wb_we,
  input  logic [`SMC_ADDR_W-1:0] wb_adr,
  input  logic [`SMC_SEL_W-1:0]  wb_sel,
  input  logic [`SMC_DATA_W-1:0] wb_dat_i,
  output logic [`SMC_DATA_W-1:0] wb_dat_o,
  output logic                   wb_ack,
  // memory pins
  output logic [`SMC_ADDR_W-1:0] smc_addr,
  output logic [`SMC_DATA_W-1:0] smc_data_out,
  output logic                   smc_n_cs,
  output logic                   smc_n_oe,
  input  logic [`SMC_DATA_W-1:0] smc_data_in,
  // raw strobes to the write enable stage
  smc_strobe_if.sequencer        strobe
);

  // last count value of each phase, counter runs down to zero
  localparam logic [`SMC_CNT_W-1:0] setup_last  = `SMC_SETUP_CYC - 1;
  localparam logic [`SMC_CNT_W-1:0] strobe_last = `SMC_STROBE_CYC - 1;
  localparam logic [`SMC_CNT_W-1:0] hold_last   = `SMC_HOLD_CYC - 1;

  smc_pkg::smc_state_t   state;
  smc_pkg::smc_state_t   next_state;
  logic [`SMC_CNT_W-1:0] phase_cnt;
  logic                  phase_done;
  logic                  req;
  logic                  take_req;
  logic [`SMC_SEL_W-1:0] sel_q;
  smc_pkg::smc_dir_t     dir_q;
  logic                  is_write;

  // counter start value for the phase being entered
  function automatic logic [`SMC_CNT_W-1:0] phase_last(input smc_pkg::smc_state_t st);
    case (st)
      smc_pkg::st_setup:  return setup_last;
      smc_pkg::st_strobe: return strobe_last;
      smc_pkg::st_hold:   return hold_last;
      default:            return '0;
    endcase
  endfunction

  assign req        = wb_cyc && wb_stb;
  // only idle accepts, so a held stb after ack is not taken twice
  assign take_req   = (state == smc_pkg::st_idle) && req;
  assign phase_done = (phase_cnt == '0);

  // --------------------
  // state machine
  // --------------------
  always_comb
  begin
    next_state = state;
    case (state)
      smc_pkg::st_idle:
        if (req)
          next_state = smc_pkg::st_setup;
      smc_pkg::st_setup:
        if (phase_done)
          next_state = smc_pkg::st_strobe;
      smc_pkg::st_strobe:
        if (phase_done)
          next_state = smc_pkg::st_hold;
      smc_pkg::st_hold:
        if (phase_done)
          next_state = smc_pkg::st_ack;
      smc_pkg::st_ack:
        next_state = smc_pkg::st_idle;
      default:
        next_state = smc_pkg::st_idle;
    endcase
  end

  always_ff @(posedge sys_clk)
  begin
    if (reset)
    begin
      state     <= smc_pkg::st_idle;
      phase_cnt <= '0;
    end
    else
    begin
      state <= next_state;
      // reload on every phase change, else count down
      if (next_state != state)
        phase_cnt <= phase_last(next_state);
      else if (!phase_done)
        phase_cnt <= phase_cnt - 1'b1;
    end
  end

  // --------------------
  // request capture
  // --------------------
  // address, data and lanes held for the whole access
  always_ff @(posedge sys_clk)
  begin
    if (take_req)
    begin
      smc_addr     <= wb_adr;
      smc_data_out <= wb_dat_i;
      sel_q        <= wb_sel;
    end
  end

  always_ff @(posedge sys_clk)
  begin
    if (reset)
      dir_q <= smc_pkg::dir_read;
    else if (take_req)
      dir_q <= wb_we ? smc_pkg::dir_write : smc_pkg::dir_read;
  end

  assign is_write = (dir_q == smc_pkg::dir_write);

  // read data sampled on the edge that ends strobe, oe still low
  always_ff @(posedge sys_clk)
  begin
    if ((state == smc_pkg::st_strobe) && phase_done)
      wb_dat_o <= smc_data_in;
  end

  // --------------------
  // registered pins and ack
  // --------------------
  // decoded from next_state so pins line up with the state
  always_ff @(posedge sys_clk)
  begin
    if (reset)
    begin
      smc_n_cs <= 1'b1;
      smc_n_oe <= 1'b1;
      wb_ack   <= 1'b0;
    end
    else
    begin
      smc_n_cs <= !((next_state == smc_pkg::st_setup) ||
                    (next_state == smc_pkg::st_strobe) ||
                    (next_state == smc_pkg::st_hold));
      smc_n_oe <= !((next_state == smc_pkg::st_strobe) && !is_write);
      wb_ack   <= (next_state == smc_pkg::st_ack);
    end
  end

  // raw strobes, one cycle ahead of the enable stage registers
  assign strobe.r_full = (next_state == smc_pkg::st_strobe);
  assign strobe.n_r_we = is_write ? ~sel_q : '1;
  assign strobe.n_r_wr = !is_write;

  // --------------------
  // checks
  // --------------------
  // master sees a single ack per access
  ack_one_cycle: assert property (@(posedge sys_clk) disable iff (reset)
    wb_ack |=> !wb_ack);

  // read enable and write strobe belong to different accesses
  oe_wr_exclusive: assert property (@(posedge sys_clk) disable iff (reset)
    !(!smc_n_oe && !strobe.n_r_wr));

endmodule

// File: smc_wr_enable.sv
/*
  write enable stage
  qualifies raw byte enables and write strobe with the
  full-cycle qualifier, registers active-low pins
*/

`timescale 1ns/10ps
`include "smc_defs.svh"

module smc_wr_enable
(
  input  logic                  sys_clk,
  input  logic                  reset,
  smc_strobe_if.enable          strobe,
  output logic [`SMC_SEL_W-1:0] smc_n_we,
  output logic                  smc_n_wr
);

  logic [`SMC_SEL_W-1:0] gated_n_we;
  logic                  gated_n_wr;

  // --------------------
  // qualifier gating
  // --------------------
  // any lane forced high outside the qualified window
  assign gated_n_we = {`SMC_SEL_W{~strobe.r_full}} | strobe.n_r_we;
  assign gated_n_wr = ~strobe.r_full | strobe.n_r_wr;

  // --------------------
  // pin registers
  // --------------------
  // pins glitch-free, idle high
  always_ff @(posedge sys_clk)
  begin
    if (reset)
    begin
      smc_n_we <= '1;
      smc_n_wr <= 1'b1;
    end
    else
    begin
      smc_n_we <= gated_n_we;
      smc_n_wr <= gated_n_wr;
    end
  end

  // lanes only ever written inside a write strobe
  we_inside_wr: assert property (@(posedge sys_clk) disable iff (reset)
    smc_n_wr |-> (&smc_n_we));

endmodule

// File: smc_top.sv
/*
  static memory controller top
  Wishbone classic slave to 32-bit SRAM-style device,
  single chip select, fixed setup/strobe/hold timing
*/

`timescale 1ns/10ps
`include "smc_defs.svh"

module smc_top
(
  input  logic                   sys_clk,
  input  logic                   reset,
  // Wishbone slave
  input  logic                   wb_cyc,
  input  logic                   wb_stb,
  input  logic                   wb_we,
  input  logic [`SMC_ADDR_W-1:0] wb_adr,
  input  logic [`SMC_SEL_W-1:0]  wb_sel,
  input  logic [`SMC_DATA_W-1:0] wb_dat_i,
  output logic [`SMC_DATA_W-1:0] wb_dat_o,
  output logic                   wb_ack,
  // memory device
  output logic [`SMC_ADDR_W-1:0] smc_addr,
  output logic [`SMC_DATA_W-1:0] smc_data_out,
  input  logic [`SMC_DATA_W-1:0] smc_data_in,
  output logic                   smc_n_cs,
  output logic                   smc_n_oe,
  output logic [`SMC_SEL_W-1:0]  smc_n_we,
  output logic                   smc_n_wr
);

  // raw strobes between the two stages
  smc_strobe_if strobe_if ();

  // sequencer, bus side and address/data path
  smc_strobe u_strobe
  (
    .sys_clk      (sys_clk),
    .reset        (reset),
    .wb_cyc       (wb_cyc),
    .wb_stb       (wb_stb),
    .wb_we        (wb_we),
    .wb_adr       (wb_adr),
    .wb_sel       (wb_sel),
    .wb_dat_i     (wb_dat_i),
    .wb_dat_o     (wb_dat_o),
    .wb_ack       (wb_ack),
    .smc_addr     (smc_addr),
    .smc_data_out (smc_data_out),
    .smc_n_cs     (smc_n_cs),
    .smc_n_oe     (smc_n_oe),
    .smc_data_in  (smc_data_in),
    .strobe       (strobe_if.sequencer)
  );

  // write enable pins
  smc_wr_enable u_wr_enable
  (
    .sys_clk  (sys_clk),
    .reset    (reset),
    .strobe   (strobe_if.enable),
    .smc_n_we (smc_n_we),
    .smc_n_wr (smc_n_wr)
  );

endmodule

// File: tb_smc_checker.sv
/*
  static memory controller checker
  watches the Wishbone and memory pins of the DUT,
  keeps a reference memory and compares pin timing and read data
*/

`timescale 1ns/10ps
`include "smc_defs.svh"

module tb_smc_checker
(
  input  logic                   sys_clk,
  input  logic                   reset,
  input  logic                   wb_cyc,
  input  logic                   wb_stb,
  input  logic                   wb_we,
  input  logic [`SMC_ADDR_W-1:0] wb_adr,
  input  logic [`SMC_SEL_W-1:0]  wb_sel,
  input  logic [`SMC_DATA_W-1:0] wb_dat_i,
  input  logic [`SMC_DATA_W-1:0] wb_dat_o,
  input  logic                   wb_ack,
  input  logic [`SMC_ADDR_W-1:0] smc_addr,
  input  logic [`SMC_DATA_W-1:0] smc_data_out,
  input  logic                   smc_n_cs,
  input  logic                   smc_n_oe,
  input  logic [`SMC_SEL_W-1:0]  smc_n_we,
  input  logic                   smc_n_wr,
  output int                     error_count,
  output int                     access_count
);

  // edge numbers counted from the edge that takes the request
  localparam int strobe_first = `SMC_SETUP_CYC + 1;
  localparam int strobe_last  = `SMC_SETUP_CYC + `SMC_STROBE_CYC;
  localparam int ack_at       = `SMC_SETUP_CYC + `SMC_STROBE_CYC + `SMC_HOLD_CYC + 1;

  logic [`SMC_DATA_W-1:0] ref_mem [0:(1 << `SMC_ADDR_W)-1];
  logic                   busy;
  int                     cnt;
  logic                   req_we;
  logic [`SMC_ADDR_W-1:0] req_adr;
  logic [`SMC_SEL_W-1:0]  req_sel;
  logic [`SMC_DATA_W-1:0] req_dat;
  logic                   in_strobe;
  logic                   exp_n_cs;
  logic                   exp_n_oe;
  logic                   exp_n_wr;
  logic [`SMC_SEL_W-1:0]  exp_n_we;

  // power-up contents, a function of the whole address
  function automatic logic [`SMC_DATA_W-1:0] fill_word(input logic [`SMC_ADDR_W-1:0] a);
    return {a ^ 10'h2b5, 6'h1c, ~a, 6'h23};
  endfunction

  // byte lanes of a write replace only the selected bytes
  function automatic logic [`SMC_DATA_W-1:0] merge_lanes(input logic [`SMC_DATA_W-1:0] old_word,
                                                         input logic [`SMC_DATA_W-1:0] wdata,
                                                         input logic [`SMC_SEL_W-1:0] sel);
    logic [`SMC_DATA_W-1:0] res;
    res = old_word;
    for (int l = 0; l < `SMC_SEL_W; l++)
      if (sel[l])
        res[l*8 +: 8] = wdata[l*8 +: 8];
    return res;
  endfunction

  task automatic check_val(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
    if (actual !== expected)
    begin
      error_count++;
      $display("error %s expected %h actual %h at %0t", name, expected, actual, $time);
    end
  endtask

  task automatic check_pins(input logic n_cs, input logic n_oe, input logic n_wr,
                            input logic [`SMC_SEL_W-1:0] n_we, input logic ack);
    check_val("smc_n_cs", 32'(n_cs), 32'(smc_n_cs));
    check_val("smc_n_oe", 32'(n_oe), 32'(smc_n_oe));
    check_val("smc_n_wr", 32'(n_wr), 32'(smc_n_wr));
    check_val("smc_n_we", 32'(n_we), 32'(smc_n_we));
    check_val("wb_ack", 32'(ack), 32'(wb_ack));
  endtask

  // --------------------
  // per-edge comparison
  // --------------------
  always @(posedge sys_clk)
  begin
    if (reset)
    begin
      busy         = 1'b0;
      cnt          = 0;
      error_count  = 0;
      access_count = 0;
      for (int a = 0; a < (1 << `SMC_ADDR_W); a++)
        ref_mem[a[`SMC_ADDR_W-1:0]] = fill_word(a[`SMC_ADDR_W-1:0]);
    end
    else if (!busy)
    begin
      // idle, all strobes released
      check_pins(1'b1, 1'b1, 1'b1, '1, 1'b0);
      if (wb_cyc && wb_stb)
      begin
        busy    = 1'b1;
        cnt     = 0;
        req_we  = wb_we;
        req_adr = wb_adr;
        req_sel = wb_sel;
        req_dat = wb_dat_i;
      end
    end
    else
    begin
      cnt++;
      in_strobe = (cnt >= strobe_first) && (cnt <= strobe_last);
      // chip select spans setup, strobe and hold
      exp_n_cs = !(cnt < ack_at);
      exp_n_oe = !(in_strobe && !req_we);
      exp_n_wr = !(in_strobe && req_we);
      exp_n_we = (in_strobe && req_we) ? ~req_sel : '1;
      check_pins(exp_n_cs, exp_n_oe, exp_n_wr, exp_n_we, cnt == ack_at);
      if (in_strobe)
      begin
        check_val("smc_addr", 32'(req_adr), 32'(smc_addr));
        if (req_we)
          check_val("smc_data_out", req_dat, smc_data_out);
      end
      if (cnt == ack_at)
      begin
        if (req_we)
          ref_mem[req_adr] = merge_lanes(ref_mem[req_adr], req_dat, req_sel);
        else
          check_val("wb_dat_o", ref_mem[req_adr], wb_dat_o);
        access_count++;
        busy = 1'b0;
      end
    end
  end

endmodule

// File: tb_smc.sv
/*
  static memory controller testbench
  clock, reset, random Wishbone accesses from an LFSR,
  SRAM device model on the memory pins, checker and watchdog
*/

`timescale 1ns/10ps
`include "smc_defs.svh"

module tb_smc;

  localparam int clk_half    = 4;
  localparam int reset_cyc   = 4;
  localparam int n_access    = 400;
  // longest access plus the longest idle gap stays well below this
  localparam int timeout_cyc = n_access * 12 + reset_cyc;

  logic                   sys_clk = 1'b0;
  logic                   reset;
  logic                   wb_cyc;
  logic                   wb_stb;
  logic                   wb_we;
  logic [`SMC_ADDR_W-1:0] wb_adr;
  logic [`SMC_SEL_W-1:0]  wb_sel;
  logic [`SMC_DATA_W-1:0] wb_dat_i;
  logic [`SMC_DATA_W-1:0] wb_dat_o;
  logic                   wb_ack;
  logic [`SMC_ADDR_W-1:0] smc_addr;
  logic [`SMC_DATA_W-1:0] smc_data_out;
  logic [`SMC_DATA_W-1:0] smc_data_in;
  logic                   smc_n_cs;
  logic                   smc_n_oe;
  logic [`SMC_SEL_W-1:0]  smc_n_we;
  logic                   smc_n_wr;
  int                     error_count;
  int                     access_count;
  logic [31:0]            lfsr_state;

  always #clk_half sys_clk = ~sys_clk;

  // --------------------
  // random numbers
  // --------------------
  // taps 32, 22, 2, 1
  function automatic logic next_bit();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
      v = {v[30:0], next_bit()};
    return v;
  endfunction

  // same power-up pattern as the reference memory
  function automatic logic [`SMC_DATA_W-1:0] fill_word(input logic [`SMC_ADDR_W-1:0] a);
    return {a ^ 10'h2b5, 6'h1c, ~a, 6'h23};
  endfunction

  // --------------------
  // SRAM device model
  // --------------------
  logic [`SMC_DATA_W-1:0] sram [0:(1 << `SMC_ADDR_W)-1];
  logic [`SMC_SEL_W-1:0]  prev_n_we;

  // lane stored on the rising edge of its write enable
  always @(smc_n_we or reset)
  begin
    if (reset)
    begin
      for (int a = 0; a < (1 << `SMC_ADDR_W); a++)
        sram[a[`SMC_ADDR_W-1:0]] = fill_word(a[`SMC_ADDR_W-1:0]);
    end
    else
    begin
      for (int lane = 0; lane < `SMC_SEL_W; lane++)
        if (smc_n_we[lane] && !prev_n_we[lane] && !smc_n_cs)
          sram[smc_addr][lane*8 +: 8] = smc_data_out[lane*8 +: 8];
    end
    prev_n_we = smc_n_we;
  end

  // output enable drives the data bus, else undriven
  assign smc_data_in = !smc_n_oe ? sram[smc_addr] : 'x;

  // --------------------
  // DUT and checker
  // --------------------
  smc_top smc_top_i
  (
    .sys_clk      (sys_clk),
    .reset        (reset),
    .wb_cyc       (wb_cyc),
    .wb_stb       (wb_stb),
    .wb_we        (wb_we),
    .wb_adr       (wb_adr),
    .wb_sel       (wb_sel),
    .wb_dat_i     (wb_dat_i),
    .wb_dat_o     (wb_dat_o),
    .wb_ack       (wb_ack),
    .smc_addr     (smc_addr),
    .smc_data_out (smc_data_out),
    .smc_data_in  (smc_data_in),
    .smc_n_cs     (smc_n_cs),
    .smc_n_oe     (smc_n_oe),
    .smc_n_we     (smc_n_we),
    .smc_n_wr     (smc_n_wr)
  );

  tb_smc_checker scoreboard_i
  (
    .sys_clk      (sys_clk),
    .reset        (reset),
    .wb_cyc       (wb_cyc),
    .wb_stb       (wb_stb),
    .wb_we        (wb_we),
    .wb_adr       (wb_adr),
    .wb_sel       (wb_sel),
    .wb_dat_i     (wb_dat_i),
    .wb_dat_o     (wb_dat_o),
    .wb_ack       (wb_ack),
    .smc_addr     (smc_addr),
    .smc_data_out (smc_data_out),
    .smc_n_cs     (smc_n_cs),
    .smc_n_oe     (smc_n_oe),
    .smc_n_we     (smc_n_we),
    .smc_n_wr     (smc_n_wr),
    .error_count  (error_count),
    .access_count (access_count)
  );

  // one Wishbone access, held until ack is seen at an edge
  task automatic run_access(input logic we, input logic [`SMC_ADDR_W-1:0] adr,
                            input logic [`SMC_SEL_W-1:0] sel,
                            input logic [`SMC_DATA_W-1:0] dat);
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_sel   = sel;
    wb_dat_i = dat;
    do
    begin
      @(posedge sys_clk);
      #1;
    end
    while (!wb_ack);
    // the next edge completes the handshake
    @(posedge sys_clk);
    #1;
  endtask

  // --------------------
  // stimulus
  // --------------------
  initial
  begin
    logic [31:0] tmp;
    logic        we;
    logic [`SMC_ADDR_W-1:0] adr;
    logic [`SMC_SEL_W-1:0]  sel;
    logic [`SMC_DATA_W-1:0] dat;
    int gap;
    lfsr_state = 32'h6437;
    reset      = 1'b1;
    wb_cyc     = 1'b0;
    wb_stb     = 1'b0;
    wb_we      = 1'b0;
    wb_adr     = '0;
    wb_sel     = '0;
    wb_dat_i   = '0;
    repeat (reset_cyc) @(posedge sys_clk);
    #1;
    reset = 1'b0;
    for (int n = 0; n < n_access; n++)
    begin
      we  = next_bit();
      tmp = rand_bits(`SMC_ADDR_W);
      adr = tmp[`SMC_ADDR_W-1:0];
      // mostly a small window so reads hit earlier writes
      if (next_bit())
        adr = {7'h7e, adr[2:0]};
      tmp = rand_bits(`SMC_SEL_W);
      sel = tmp[`SMC_SEL_W-1:0];
      dat = rand_bits(`SMC_DATA_W);
      run_access(we, adr, sel, dat);
      tmp = rand_bits(2);
      gap = tmp;
      if (gap != 0)
      begin
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        repeat (gap) @(posedge sys_clk);
        #1;
      end
    end
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    repeat (4) @(posedge sys_clk);
    #1;
    $display("accesses %0d of %0d, errors %0d", access_count, n_access, error_count);
    if (access_count != n_access)
      $display("checker did not see every access complete");
    if ((error_count == 0) && (access_count == n_access))
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

  // watchdog
  initial
  begin
    repeat (timeout_cyc) @(posedge sys_clk);
    $display("timeout, accesses did not finish within %0d cycles", timeout_cyc);
    $display("Testbench failed");
    $finish;
  end

endmodule

// File: verilog.f
+incdir+.
smc_pkg.sv
smc_strobe_if.sv
smc_strobe.sv
smc_wr_enable.sv
smc_top.sv
tb_smc_checker.sv
tb_smc.sv

// File: run.sh
#!/bin/sh
# compile and run the static memory controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module tb_smc > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
  cat build.log
  echo "verilator build failed with status $status"
  exit 1
fi

./obj_dir/Vtb_smc > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Testbench failed" sim.log; then
  exit 1
fi
exit 0
